/* common/issue_consts.svh */
/*
  Scheduler constants
  Queue depth, tag and opcode widths, issue widths and opcode decode bits
*/

`ifndef ISSUE_CONSTS_SVH
`define ISSUE_CONSTS_SVH

`define ISSUE_QUEUE_ENTRY_NUM 8
`define TAG_WIDTH 5
`define OPCODE_WIDTH 4

`define INT_ISSUE_WIDTH 1
`define MEM_ISSUE_WIDTH 1

// Opcode bit positions
`define OPCODE_MEM_BIT 3
`define OPCODE_IMM_BIT 2

`endif

/* common/BasicTypes.sv */
/*
  BasicTypes
  Plain vector types shared by every block of the scheduler
*/

`include "issue_consts.svh"

package BasicTypes;

    // Physical register tag
    typedef logic [`TAG_WIDTH-1:0] TagPath;

    // Raw opcode as it comes from the front end
    typedef logic [`OPCODE_WIDTH-1:0] OpcodePath;

endpackage : BasicTypes

/* common/SchedulerTypes.sv */
/*
  SchedulerTypes
  Pipe classes, issue queue entry layout and per-entry vectors
*/

`include "issue_consts.svh"

package SchedulerTypes;

    typedef enum logic {
        PIPE_INT = 1'b0,
        PIPE_MEM = 1'b1
    } PipeClass;

    // One bit per queue entry
    typedef logic [`ISSUE_QUEUE_ENTRY_NUM-1:0] IssueQueueOneHotPath;
    typedef logic [$clog2(`ISSUE_QUEUE_ENTRY_NUM)-1:0] IssueQueueIndexPath;

    typedef struct packed {
        BasicTypes::OpcodePath opcode;
        PipeClass pipe;
        BasicTypes::TagPath dest;
        BasicTypes::TagPath src1;
        BasicTypes::TagPath src2;
        logic src2Used;     // Cleared for immediate forms
        logic src1Ready;
        logic src2Ready;
    } SchedulerEntry;

endpackage : SchedulerTypes

/* common/WakeupSelectIF.sv */
/*
  WakeupSelectIF
  Ready and request vectors from the issue queue, grants from the select
  logic and stall flags from the issue stage
*/

`include "issue_consts.svh"

interface WakeupSelectIF;

    SchedulerTypes::IssueQueueOneHotPath opReady;
    SchedulerTypes::IssueQueueOneHotPath intIssueReq;
    SchedulerTypes::IssueQueueOneHotPath memIssueReq;

    SchedulerTypes::IssueQueueOneHotPath intGrant;
    SchedulerTypes::IssueQueueOneHotPath memGrant;
    logic intSelected[`INT_ISSUE_WIDTH];
    logic memSelected[`MEM_ISSUE_WIDTH];
    SchedulerTypes::IssueQueueIndexPath intSelectedPtr[`INT_ISSUE_WIDTH];
    SchedulerTypes::IssueQueueIndexPath memSelectedPtr[`MEM_ISSUE_WIDTH];

    logic intStall;
    logic memStall;

    modport IssueQueue(
        output opReady, intIssueReq, memIssueReq,
        input intGrant, memGrant, intSelectedPtr, memSelectedPtr
    );

    modport SelectLogic(
        input opReady, intIssueReq, memIssueReq, intStall, memStall,
        output intGrant, memGrant, intSelected, memSelected, intSelectedPtr, memSelectedPtr
    );

    modport IssueStage(
        input intSelected, memSelected,
        output intStall, memStall
    );

endinterface : WakeupSelectIF

/* scheduler/Picker.sv */
/*
  Picker
  Grants up to GRANT_NUM requests, lowest index first, with their indices
*/

module Picker #(
    parameter int ENTRY_NUM = 8,
    parameter int GRANT_NUM = 1
)(
    input logic [ENTRY_NUM-1:0] req,
    output logic [ENTRY_NUM-1:0] grant,
    output logic [$clog2(ENTRY_NUM)-1:0] grantPtr[GRANT_NUM],
    output logic granted[GRANT_NUM]
);

    localparam int PTR_WIDTH = $clog2(ENTRY_NUM);

    logic [ENTRY_NUM-1:0] remain;

    always_comb begin
        remain = req;
        grant = '0;
        for (int g = 0; g < GRANT_NUM; g++) begin
            granted[g] = 1'b0;
            grantPtr[g] = '0;
            for (int i = 0; i < ENTRY_NUM; i++) begin
                if (remain[i] && !granted[g]) begin
                    granted[g] = 1'b1;
                    grantPtr[g] = PTR_WIDTH'(i);
                    remain[i] = 1'b0;
                    grant[i] = 1'b1;
                end
            end
        end
    end

    always_comb begin
        assert ((grant & ~req) == '0)
            else $error("Picker granted an entry without a request");
    end

endmodule : Picker

/* scheduler/SelectLogic.sv */
/*
  SelectLogic
  Per-class request masking and one picker per pipe
*/

`include "issue_consts.svh"

module SelectLogic(
    WakeupSelectIF.SelectLogic port
);

    SchedulerTypes::IssueQueueOneHotPath intRequest;
    SchedulerTypes::IssueQueueOneHotPath memRequest;
    SchedulerTypes::IssueQueueOneHotPath intGrant;
    SchedulerTypes::IssueQueueOneHotPath memGrant;
    logic intSelected[`INT_ISSUE_WIDTH];
    logic memSelected[`MEM_ISSUE_WIDTH];
    SchedulerTypes::IssueQueueIndexPath intSelectedPtr[`INT_ISSUE_WIDTH];
    SchedulerTypes::IssueQueueIndexPath memSelectedPtr[`MEM_ISSUE_WIDTH];

    // A stalled pipe gets no requests at all
    always_comb begin
        intRequest = port.opReady & port.intIssueReq &
                     {`ISSUE_QUEUE_ENTRY_NUM{!port.intStall}};
        memRequest = port.opReady & port.memIssueReq &
                     {`ISSUE_QUEUE_ENTRY_NUM{!port.memStall}};
    end

    Picker #(
        .ENTRY_NUM(`ISSUE_QUEUE_ENTRY_NUM),
        .GRANT_NUM(`INT_ISSUE_WIDTH)
    ) intPicker (
        .req(intRequest),
        .grant(intGrant),
        .grantPtr(intSelectedPtr),
        .granted(intSelected)
    );

    Picker #(
        .ENTRY_NUM(`ISSUE_QUEUE_ENTRY_NUM),
        .GRANT_NUM(`MEM_ISSUE_WIDTH)
    ) memPicker (
        .req(memRequest),
        .grant(memGrant),
        .grantPtr(memSelectedPtr),
        .granted(memSelected)
    );

    always_comb begin
        port.intGrant = intGrant;
        port.memGrant = memGrant;
        port.intSelected = intSelected;
        port.memSelected = memSelected;
        port.intSelectedPtr = intSelectedPtr;
        port.memSelectedPtr = memSelectedPtr;
    end

    always_comb begin
        assert ($onehot0(intGrant) && $onehot0(memGrant))
            else $error("Select grant is not one-hot");
    end

endmodule : SelectLogic

/* scheduler/IssueQueue.sv */
/*
  IssueQueue
  Eight scheduler entries with lowest-free allocation, tag wakeup,
  request generation and release on issue
*/

`include "issue_consts.svh"

module IssueQueue(
    input logic clk,
    input logic rstN,
    input logic allocate,
    input SchedulerTypes::SchedulerEntry allocEntry,
    output logic queueFull,
    input logic intWakeupValid,
    input logic memWakeupValid,
    input BasicTypes::TagPath intWakeupTag,
    input BasicTypes::TagPath memWakeupTag,
    WakeupSelectIF.IssueQueue sel,
    input logic intRelease,
    input logic memRelease,
    output SchedulerTypes::SchedulerEntry intEntry,
    output SchedulerTypes::SchedulerEntry memEntry
);

    SchedulerTypes::SchedulerEntry entries[`ISSUE_QUEUE_ENTRY_NUM];
    SchedulerTypes::IssueQueueOneHotPath entryValid;
    SchedulerTypes::IssueQueueOneHotPath allocOneHot;
    SchedulerTypes::IssueQueueOneHotPath releaseOneHot;
    SchedulerTypes::IssueQueueOneHotPath src1Hit;
    SchedulerTypes::IssueQueueOneHotPath src2Hit;

    always_comb begin
        // Lowest clear bit of the valid vector
        allocOneHot = ~entryValid & (entryValid + 1'b1);
        queueFull = &entryValid;

        releaseOneHot = (sel.intGrant & {`ISSUE_QUEUE_ENTRY_NUM{intRelease}}) |
                        (sel.memGrant & {`ISSUE_QUEUE_ENTRY_NUM{memRelease}});

        for (int i = 0; i < `ISSUE_QUEUE_ENTRY_NUM; i++) begin
            src1Hit[i] = (intWakeupValid && entries[i].src1 == intWakeupTag) ||
                         (memWakeupValid && entries[i].src1 == memWakeupTag);
            src2Hit[i] = entries[i].src2Used &&
                         ((intWakeupValid && entries[i].src2 == intWakeupTag) ||
                          (memWakeupValid && entries[i].src2 == memWakeupTag));

            sel.opReady[i] = entryValid[i] && entries[i].src1Ready && entries[i].src2Ready;
            sel.intIssueReq[i] = entryValid[i] && entries[i].pipe == SchedulerTypes::PIPE_INT;
            sel.memIssueReq[i] = entryValid[i] && entries[i].pipe == SchedulerTypes::PIPE_MEM;
        end

        // Read ports for the issue stage
        intEntry = entries[sel.intSelectedPtr[0]];
        memEntry = entries[sel.memSelectedPtr[0]];
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            entryValid <= '0;
        end else begin
            entryValid <= (entryValid & ~releaseOneHot) |
                          (allocOneHot & {`ISSUE_QUEUE_ENTRY_NUM{allocate}});
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `ISSUE_QUEUE_ENTRY_NUM; i++) begin
            if (allocate && allocOneHot[i]) begin
                entries[i] <= allocEntry;
            end else begin
                if (src1Hit[i]) begin
                    entries[i].src1Ready <= 1'b1;
                end
                if (src2Hit[i]) begin
                    entries[i].src2Ready <= 1'b1;
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rstN) (releaseOneHot & ~entryValid) == '0)
        else $error("Issue stage released an invalid queue entry");

endmodule : IssueQueue

/* design/DispatchDecoder.sv */
/*
  DispatchDecoder
  Accepts one operation per cycle and builds its issue queue entry
*/

`include "issue_consts.svh"

module DispatchDecoder(
    input logic clk,
    input logic rstN,
    input logic dispatchValid,
    input BasicTypes::OpcodePath dispatchOpcode,
    input BasicTypes::TagPath dispatchDest,
    input BasicTypes::TagPath dispatchSrc1,
    input BasicTypes::TagPath dispatchSrc2,
    input logic dispatchSrc1Ready,
    input logic dispatchSrc2Ready,
    output logic dispatchReady,
    input logic queueFull,
    input logic intWakeupValid,
    input BasicTypes::TagPath intWakeupTag,
    input logic memWakeupValid,
    input BasicTypes::TagPath memWakeupTag,
    output logic allocate,
    output SchedulerTypes::SchedulerEntry allocEntry
);

    logic isImm;
    logic src1Bypass;
    logic src2Bypass;

    always_comb begin
        dispatchReady = !queueFull;
        allocate = dispatchValid && !queueFull;
        isImm = dispatchOpcode[`OPCODE_IMM_BIT];

        // A producer leaving on this edge is not seen by the queue entry
        src1Bypass = (intWakeupValid && intWakeupTag == dispatchSrc1) ||
                     (memWakeupValid && memWakeupTag == dispatchSrc1);
        src2Bypass = (intWakeupValid && intWakeupTag == dispatchSrc2) ||
                     (memWakeupValid && memWakeupTag == dispatchSrc2);

        allocEntry.opcode = dispatchOpcode;
        allocEntry.pipe = dispatchOpcode[`OPCODE_MEM_BIT] ?
            SchedulerTypes::PIPE_MEM : SchedulerTypes::PIPE_INT;
        allocEntry.dest = dispatchDest;
        allocEntry.src1 = dispatchSrc1;
        allocEntry.src2 = dispatchSrc2;
        allocEntry.src2Used = !isImm;
        allocEntry.src1Ready = dispatchSrc1Ready || src1Bypass;
        allocEntry.src2Ready = isImm || dispatchSrc2Ready || src2Bypass;
    end

    // The queue only becomes full through an allocation from this port
    assert property (@(posedge clk) disable iff (!rstN) $rose(queueFull) |-> $past(allocate))
        else $error("Issue queue became full without an allocation");

endmodule : DispatchDecoder

/* design/IssueStage.sv */
/*
  IssueStage
  One issue register per pipe with valid/ready output and tag broadcast
  on every output transfer
*/

module IssueStage(
    input logic clk,
    input logic rstN,
    WakeupSelectIF.IssueStage sel,
    input SchedulerTypes::SchedulerEntry intEntry,
    input SchedulerTypes::SchedulerEntry memEntry,
    output logic intRelease,
    output logic memRelease,
    output logic intIssueValid,
    input logic intIssueReady,
    output BasicTypes::OpcodePath intIssueOpcode,
    output BasicTypes::TagPath intIssueDest,
    output logic memIssueValid,
    input logic memIssueReady,
    output BasicTypes::OpcodePath memIssueOpcode,
    output BasicTypes::TagPath memIssueDest,
    output logic intWakeupValid,
    output BasicTypes::TagPath intWakeupTag,
    output logic memWakeupValid,
    output BasicTypes::TagPath memWakeupTag
);

    // Slot 0 is the integer pipe, slot 1 the memory pipe
    logic [1:0] regValid;
    BasicTypes::OpcodePath regOpcode[2];
    BasicTypes::TagPath regDest[2];
    SchedulerTypes::SchedulerEntry inEntry[2];
    logic [1:0] outReady;
    logic [1:0] stall;
    logic [1:0] load;
    logic [1:0] transfer;

    always_comb begin
        inEntry[0] = intEntry;
        inEntry[1] = memEntry;
        outReady = {memIssueReady, intIssueReady};
        transfer = regValid & outReady;
        stall = regValid & ~outReady;
        // Select logic gives no grant to a stalled pipe
        load[0] = sel.intSelected[0];
        load[1] = sel.memSelected[0];
    end

    always_comb begin
        sel.intStall = stall[0];
        sel.memStall = stall[1];
        intRelease = load[0];
        memRelease = load[1];

        intIssueValid = regValid[0];
        intIssueOpcode = regOpcode[0];
        intIssueDest = regDest[0];
        memIssueValid = regValid[1];
        memIssueOpcode = regOpcode[1];
        memIssueDest = regDest[1];

        intWakeupValid = transfer[0];
        intWakeupTag = regDest[0];
        memWakeupValid = transfer[1];
        memWakeupTag = regDest[1];
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            regValid <= '0;
        end else begin
            regValid <= load | (regValid & ~transfer);
        end
    end

    always_ff @(posedge clk) begin
        for (int c = 0; c < 2; c++) begin
            if (load[c]) begin
                regOpcode[c] <= inEntry[c].opcode;
                regDest[c] <= inEntry[c].dest;
            end
        end
    end

    for (genvar c = 0; c < 2; c++) begin : gHoldCheck
        assert property (@(posedge clk) disable iff (!rstN)
            regValid[c] && !outReady[c] |=>
                regValid[c] && $stable(regOpcode[c]) && $stable(regDest[c]))
            else $error("Issue payload changed under back-pressure");
    end

endmodule : IssueStage

/* design/SchedulerTop.sv */
/*
  SchedulerTop
  Dispatch decoder, issue queue, select logic and issue stage
*/

module SchedulerTop(
    input logic clk,
    input logic rstN,
    input logic dispatchValid,
    input BasicTypes::OpcodePath dispatchOpcode,
    input BasicTypes::TagPath dispatchDest,
    input BasicTypes::TagPath dispatchSrc1,
    input BasicTypes::TagPath dispatchSrc2,
    input logic dispatchSrc1Ready,
    input logic dispatchSrc2Ready,
    output logic dispatchReady,
    output logic intIssueValid,
    input logic intIssueReady,
    output BasicTypes::OpcodePath intIssueOpcode,
    output BasicTypes::TagPath intIssueDest,
    output logic memIssueValid,
    input logic memIssueReady,
    output BasicTypes::OpcodePath memIssueOpcode,
    output BasicTypes::TagPath memIssueDest
);

    logic queueFull;
    logic allocate;
    SchedulerTypes::SchedulerEntry allocEntry;
    SchedulerTypes::SchedulerEntry intEntry;
    SchedulerTypes::SchedulerEntry memEntry;
    logic intRelease;
    logic memRelease;
    logic intWakeupValid;
    logic memWakeupValid;
    BasicTypes::TagPath intWakeupTag;
    BasicTypes::TagPath memWakeupTag;

    WakeupSelectIF wsIf();

    DispatchDecoder decoder (
        .clk(clk),
        .rstN(rstN),
        .dispatchValid(dispatchValid),
        .dispatchOpcode(dispatchOpcode),
        .dispatchDest(dispatchDest),
        .dispatchSrc1(dispatchSrc1),
        .dispatchSrc2(dispatchSrc2),
        .dispatchSrc1Ready(dispatchSrc1Ready),
        .dispatchSrc2Ready(dispatchSrc2Ready),
        .dispatchReady(dispatchReady),
        .queueFull(queueFull),
        .intWakeupValid(intWakeupValid),
        .intWakeupTag(intWakeupTag),
        .memWakeupValid(memWakeupValid),
        .memWakeupTag(memWakeupTag),
        .allocate(allocate),
        .allocEntry(allocEntry)
    );

    IssueQueue issueQueue (
        .clk(clk),
        .rstN(rstN),
        .allocate(allocate),
        .allocEntry(allocEntry),
        .queueFull(queueFull),
        .intWakeupValid(intWakeupValid),
        .memWakeupValid(memWakeupValid),
        .intWakeupTag(intWakeupTag),
        .memWakeupTag(memWakeupTag),
        .sel(wsIf.IssueQueue),
        .intRelease(intRelease),
        .memRelease(memRelease),
        .intEntry(intEntry),
        .memEntry(memEntry)
    );

    SelectLogic selectLogic (
        .port(wsIf.SelectLogic)
    );

    IssueStage issueStage (
        .clk(clk),
        .rstN(rstN),
        .sel(wsIf.IssueStage),
        .intEntry(intEntry),
        .memEntry(memEntry),
        .intRelease(intRelease),
        .memRelease(memRelease),
        .intIssueValid(intIssueValid),
        .intIssueReady(intIssueReady),
        .intIssueOpcode(intIssueOpcode),
        .intIssueDest(intIssueDest),
        .memIssueValid(memIssueValid),
        .memIssueReady(memIssueReady),
        .memIssueOpcode(memIssueOpcode),
        .memIssueDest(memIssueDest),
        .intWakeupValid(intWakeupValid),
        .intWakeupTag(intWakeupTag),
        .memWakeupValid(memWakeupValid),
        .memWakeupTag(memWakeupTag)
    );

endmodule : SchedulerTop

/* sim/SchedulerTb.sv */
/*
  SchedulerTb
  File-driven testbench for the scheduler with a tag scoreboard model
*/

`include "issue_consts.svh"

module SchedulerTb;

    localparam int SLOTS = 16;
    localparam int MAX_LINES = 64;

    logic clk;
    logic rstN;
    logic dispatchValid;
    BasicTypes::OpcodePath dispatchOpcode;
    BasicTypes::TagPath dispatchDest;
    BasicTypes::TagPath dispatchSrc1;
    BasicTypes::TagPath dispatchSrc2;
    logic dispatchSrc1Ready;
    logic dispatchSrc2Ready;
    logic dispatchReady;
    logic intIssueValid;
    logic intIssueReady;
    BasicTypes::OpcodePath intIssueOpcode;
    BasicTypes::TagPath intIssueDest;
    logic memIssueValid;
    logic memIssueReady;
    BasicTypes::OpcodePath memIssueOpcode;
    BasicTypes::TagPath memIssueDest;

    // Columns: test, opcode, dest, src1, src2, rdy1, rdy2, intStall, memStall
    int stim[MAX_LINES][9];
    int numLines = 0;
    logic loaded = 1'b0;
    int errors = 0;
    int cycle = 0;
    int intPct = 0;
    int memPct = 0;
    int opsInTest = 0;
    logic dispAccepted;

    // Scoreboard of operations between dispatch and output transfer
    logic sValid[SLOTS];
    logic sShown[SLOTS];
    logic sNeed1[SLOTS];
    logic sNeed2[SLOTS];
    logic sFast[SLOTS];
    BasicTypes::OpcodePath sOpc[SLOTS];
    BasicTypes::TagPath sDest[SLOTS];
    BasicTypes::TagPath sSrc1[SLOTS];
    BasicTypes::TagPath sSrc2[SLOTS];
    int sAccept[SLOTS];
    logic tagDone[32];
    int doneEdge[32];

    // Output state as seen just before the coming rising edge
    logic pIntV;
    logic pIntR;
    logic pMemV;
    logic pMemR;
    logic pDispReady;
    BasicTypes::OpcodePath pIntOpc;
    BasicTypes::OpcodePath pMemOpc;
    BasicTypes::TagPath pIntDest;
    BasicTypes::TagPath pMemDest;

    SchedulerTop dut (
        .clk(clk),
        .rstN(rstN),
        .dispatchValid(dispatchValid),
        .dispatchOpcode(dispatchOpcode),
        .dispatchDest(dispatchDest),
        .dispatchSrc1(dispatchSrc1),
        .dispatchSrc2(dispatchSrc2),
        .dispatchSrc1Ready(dispatchSrc1Ready),
        .dispatchSrc2Ready(dispatchSrc2Ready),
        .dispatchReady(dispatchReady),
        .intIssueValid(intIssueValid),
        .intIssueReady(intIssueReady),
        .intIssueOpcode(intIssueOpcode),
        .intIssueDest(intIssueDest),
        .memIssueValid(memIssueValid),
        .memIssueReady(memIssueReady),
        .memIssueOpcode(memIssueOpcode),
        .memIssueDest(memIssueDest)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic reportFail(string msg);
        $display("FAIL %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic readStimulus();
        int fd;
        int code;
        string line;
        int f[9];
        fd = $fopen("sim/sched_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file sim/sched_input.txt");
            errors++;
        end else begin
            while (!$feof(fd) && numLines < MAX_LINES) begin
                line = "";
                code = $fgets(line, fd);
                code = $sscanf(line, "%d %h %d %d %d %d %d %d %d", f[0], f[1], f[2],
                               f[3], f[4], f[5], f[6], f[7], f[8]);
                if (code == 9) begin
                    stim[numLines] = f;
                    numLines++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic driveDispatch(int i);
        dispatchValid = 1'b1;
        dispatchOpcode = BasicTypes::OpcodePath'(stim[i][1]);
        dispatchDest = BasicTypes::TagPath'(stim[i][2]);
        dispatchSrc1 = BasicTypes::TagPath'(stim[i][3]);
        dispatchSrc2 = BasicTypes::TagPath'(stim[i][4]);
        // Rename view: a producer that already left counts as ready
        dispatchSrc1Ready = stim[i][5] != 0 || tagDone[dispatchSrc1];
        dispatchSrc2Ready = stim[i][6] != 0 || tagDone[dispatchSrc2];
        intPct = stim[i][7];
        memPct = stim[i][8];
    endtask

    task automatic retireOp(BasicTypes::TagPath dest);
        for (int s = 0; s < SLOTS; s++) begin
            if (sValid[s] && sShown[s] && sDest[s] == dest) begin
                sValid[s] = 1'b0;
            end
        end
        tagDone[dest] = 1'b1;
        doneEdge[dest] = cycle;
    endtask

    task automatic recordDispatch();
        int s;
        logic busy;
        s = -1;
        busy = 1'b0;
        for (int k = 0; k < SLOTS; k++) begin
            if (sValid[k] && !sShown[k] && sOpc[k][3] == dispatchOpcode[3]) begin
                busy = 1'b1;
            end
            if (!sValid[k] && s < 0) begin
                s = k;
            end
        end
        assert (s >= 0) else reportFail("more operations in flight than the model can track");
        if (s >= 0) begin
            sValid[s] = 1'b1;
            sShown[s] = 1'b0;
            sOpc[s] = dispatchOpcode;
            sDest[s] = dispatchDest;
            sSrc1[s] = dispatchSrc1;
            sSrc2[s] = dispatchSrc2;
            sNeed1[s] = !dispatchSrc1Ready;
            sNeed2[s] = !dispatchSrc2Ready && !dispatchOpcode[2];
            // Nothing older of this class ahead, so two-cycle issue is expected
            sFast[s] = !busy && !sNeed1[s] && !sNeed2[s];
            sAccept[s] = cycle;
            tagDone[dispatchDest] = 1'b0;
            opsInTest++;
        end
    endtask

    task automatic showOp(logic isMem, BasicTypes::OpcodePath opc, BasicTypes::TagPath dest);
        int s;
        s = -1;
        for (int k = 0; k < SLOTS; k++) begin
            if (sValid[k] && !sShown[k] && sDest[k] == dest && s < 0) begin
                s = k;
            end
        end
        assert (s >= 0) else reportFail($sformatf("unexpected issue of dest %0d", dest));
        if (s >= 0) begin
            assert (sOpc[s] == opc && sOpc[s][3] == isMem)
                else reportFail($sformatf("dest %0d left with opcode %h on pipe %0d",
                                          dest, opc, isMem));
            assert (!sNeed1[s] || (tagDone[sSrc1[s]] && doneEdge[sSrc1[s]] < cycle))
                else reportFail($sformatf("dest %0d issued before src1 %0d", dest, sSrc1[s]));
            assert (!sNeed2[s] || (tagDone[sSrc2[s]] && doneEdge[sSrc2[s]] < cycle))
                else reportFail($sformatf("dest %0d issued before src2 %0d", dest, sSrc2[s]));
            sShown[s] = 1'b1;
        end
    endtask

    task automatic checkPort(logic isMem, logic pV, logic pR, logic v,
                             BasicTypes::OpcodePath opc, BasicTypes::TagPath dest,
                             BasicTypes::OpcodePath pOpc, BasicTypes::TagPath pDest);
        if (pV && !pR) begin
            assert (v && opc == pOpc && dest == pDest)
                else reportFail($sformatf("pipe %0d output changed while stalled", isMem));
        end else if (v) begin
            showOp(isMem, opc, dest);
        end
    endtask

    task automatic observeEdge();
        int occ;
        logic held;
        occ = 0;
        if (pIntV && pIntR) begin
            retireOp(pIntDest);
        end
        if (pMemV && pMemR) begin
            retireOp(pMemDest);
        end
        dispAccepted = dispatchValid && pDispReady;
        if (dispAccepted) begin
            recordDispatch();
        end
        checkPort(1'b0, pIntV, pIntR, intIssueValid, intIssueOpcode, intIssueDest,
                  pIntOpc, pIntDest);
        checkPort(1'b1, pMemV, pMemR, memIssueValid, memIssueOpcode, memIssueDest,
                  pMemOpc, pMemDest);
        for (int s = 0; s < SLOTS; s++) begin
            if (sValid[s] && sFast[s] && sAccept[s] == cycle - 1) begin
                held = sOpc[s][3] ? (pMemV && !pMemR) : (pIntV && !pIntR);
                assert (sShown[s] || held)
                    else reportFail($sformatf("dest %0d not issued two cycles after dispatch",
                                              sDest[s]));
                sFast[s] = 1'b0;
            end
            if (sValid[s] && !sShown[s]) begin
                occ++;
            end
        end
        assert (dispatchReady == (occ < `ISSUE_QUEUE_ENTRY_NUM))
            else reportFail($sformatf("dispatchReady %0b with %0d queued", dispatchReady, occ));
    endtask

    task automatic takeSnapshot();
        pIntV = intIssueValid;
        pIntR = intIssueReady;
        pIntOpc = intIssueOpcode;
        pIntDest = intIssueDest;
        pMemV = memIssueValid;
        pMemR = memIssueReady;
        pMemOpc = memIssueOpcode;
        pMemDest = memIssueDest;
        pDispReady = dispatchReady;
    endtask

    task automatic stepCycle();
        @(negedge clk);
        cycle++;
        observeEdge();
        intIssueReady = int'($urandom_range(99)) >= intPct;
        memIssueReady = int'($urandom_range(99)) >= memPct;
        takeSnapshot();
    endtask

    function automatic int pendingOps();
        int n;
        n = 0;
        for (int s = 0; s < SLOTS; s++) begin
            if (sValid[s]) begin
                n++;
            end
        end
        return n;
    endfunction

    initial begin
        int li;
        int t;
        int errStart;
        int seedInit;
        int testsPassed;
        int testsFailed;
        testsPassed = 0;
        testsFailed = 0;
        seedInit = $urandom(20);
        rstN = 1'b0;
        dispatchValid = 1'b0;
        dispatchOpcode = '0;
        dispatchDest = '0;
        dispatchSrc1 = '0;
        dispatchSrc2 = '0;
        dispatchSrc1Ready = 1'b0;
        dispatchSrc2Ready = 1'b0;
        intIssueReady = 1'b0;
        memIssueReady = 1'b0;
        for (int s = 0; s < SLOTS; s++) begin
            sValid[s] = 1'b0;
            sShown[s] = 1'b0;
            sFast[s] = 1'b0;
        end
        // Tags not yet produced in the run are not ready
        for (int g = 0; g < 32; g++) begin
            tagDone[g] = 1'b0;
            doneEdge[g] = 0;
        end
        readStimulus();
        loaded = 1'b1;
        repeat (3) @(negedge clk);
        rstN = 1'b1;
        assert (!intIssueValid && !memIssueValid && dispatchReady)
            else reportFail("issue valids or dispatchReady wrong after reset");
        takeSnapshot();

        li = 0;
        while (li < numLines) begin
            t = stim[li][0];
            errStart = errors;
            opsInTest = 0;
            while (li < numLines && stim[li][0] == t) begin
                driveDispatch(li);
                stepCycle();
                while (!dispAccepted) begin
                    driveDispatch(li);
                    stepCycle();
                end
                li++;
            end
            dispatchValid = 1'b0;
            while (pendingOps() > 0) begin
                stepCycle();
            end
            if (errors == errStart) begin
                testsPassed++;
            end else begin
                testsFailed++;
            end
            $display("Test %0d: %0d ops, %0d errors", t, opsInTest, errors - errStart);
        end

        $display("Tests passed: %0d, tests failed: %0d", testsPassed, testsFailed);
        if (errors == 0 && testsFailed == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // Watchdog sized from the number of stimulus lines
    initial begin
        wait (loaded);
        repeat (200 * (numLines + 1)) @(posedge clk);
        $display("Timeout: operations still stuck in the scheduler after %0d cycles", cycle);
        $display("Test failures found");
        $finish;
    end

endmodule : SchedulerTb

/* sim/sched_input.txt */
# test opcode(hex) dest src1 src2 src1Rdy src2Rdy intStall% memStall%
# unmet sources name the dest of an earlier line in the same test
1 1 3 1 2 1 1 0 0
2 c 4 1 9 1 0 0 0
2 0 5 4 2 0 1 0 0
2 5 6 5 7 0 0 0 0
3 1 8 2 3 1 1 30 30
3 9 9 8 3 0 1 30 30
3 2 10 9 8 0 0 30 30
3 a 11 10 1 0 1 30 30
3 0 12 11 9 0 0 30 30
3 8 13 1 2 1 1 30 30
4 8 20 1 2 1 1 0 100
4 0 21 20 1 0 1 0 100
4 4 22 20 0 0 0 0 100
4 1 23 20 21 0 0 0 100
4 2 24 20 3 0 1 0 100
4 3 25 20 22 0 0 0 100
4 6 26 20 5 0 0 0 100
4 0 27 20 6 0 1 0 100
4 1 28 20 23 0 0 0 100
4 5 29 20 4 0 0 0 0
5 8 1 2 3 1 1 70 70
5 0 2 4 5 1 1 70 70
5 c 3 1 0 0 0 70 70
5 3 4 2 3 0 0 70 70
5 9 5 4 1 0 1 70 70

/* verilog.f */
+incdir+common
common/BasicTypes.sv
common/SchedulerTypes.sv
common/WakeupSelectIF.sv
scheduler/Picker.sv
scheduler/SelectLogic.sv
scheduler/IssueQueue.sv
design/DispatchDecoder.sv
design/IssueStage.sv
design/SchedulerTop.sv
sim/SchedulerTb.sv

/* run.sh */
#!/bin/sh
# Compile the scheduler testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module SchedulerTb -f verilog.f \
    || { echo "Build failed"; exit 1; }
result=$(./obj_dir/VSchedulerTb) || true
echo "$result"
echo "$result" | grep -qx 'All tests passed!' && echo "Simulation PASSED" \
    || { echo "Simulation FAILED"; exit 1; }
